/* compile.f */
+incdir+src
src/csi_rx_pkg.sv
src/csi_sync_detector.sv
src/csi_lane_aligner.sv
src/csi_header_decoder.sv
src/csi_line_writer.sv
src/csi_rx_top.sv
verif/csi_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f compile.f --top-module csi_rx_tb -o csi_rx_sim
./obj_dir/csi_rx_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0

/* verif/csi_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_defines.svh"

module csi_rx_tb;

	import csi_rx_pkg::*;

	typedef struct packed {
		logic                 uneven;
		logic [`CSI_DT_W-1:0] dt;
		logic [`CSI_WC_W-1:0] wc;
		logic                 bad_ecc;
		logic                 bad_crc;
	} burst_t;

	localparam logic [31:0] SEED = 32'hed68d31b;

	// ECC column code of each header bit from bit 23 down to bit 0
	localparam logic [143:0] ECC_COLS = {
		6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
		6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
		6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
	};

	logic                     mipi_clk_2;
	logic                     reset;
	logic                     hs_active_i;
	logic [`CSI_NIBBLE_W-1:0] lane0_nibble_i;
	logic [`CSI_NIBBLE_W-1:0] lane1_nibble_i;
	pixel_word_t              pixel_o;
	logic                     pix_valid_o;
	crc_result_t              crc_o;
	logic                     crc_valid_o;

	string       names[$];
	burst_t      tests[$];
	string       cur_name = "reset";
	integer      seed = SEED;
	int          cycle_cnt = 0;
	int          limit = 0;
	logic [31:0] words_q[$];
	logic [7:0]  lane0_q[$];
	logic [7:0]  lane1_q[$];
	pixel_word_t pix_exp[$];
	crc_result_t crc_exp[$];

	// line writer model state
	logic                   m_armed = 1'b0;
	logic [`CSI_WC_W-1:0]   m_left = '0;
	logic [`CSI_ADDR_W-1:0] m_addr = '0;
	logic [`CSI_ADDR_W-1:0] m_col = '0;
	logic [`CSI_ADDR_W-1:0] m_line = '0;
	logic [15:0]            m_crc = `CSI_CRC_INIT;

	csi_rx_top dut (
		.mipi_clk_2     (mipi_clk_2),
		.reset          (reset),
		.hs_active_i    (hs_active_i),
		.lane0_nibble_i (lane0_nibble_i),
		.lane1_nibble_i (lane1_nibble_i),
		.pixel_o        (pixel_o),
		.pix_valid_o    (pix_valid_o),
		.crc_o          (crc_o),
		.crc_valid_o    (crc_valid_o)
	);

	initial begin
		mipi_clk_2 = 1'b0;
		forever #4 mipi_clk_2 = ~mipi_clk_2;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [5:0] header_ecc(input logic [23:0] d);
		logic [5:0] e;
		e = '0;
		for (int i = 0; i < 24; i++) begin
			if (d[i]) begin
				e = e ^ ECC_COLS[6*i +: 6];
			end
		end
		return e;
	endfunction

	// reflected CRC-16 with poly 0x1021 over bytes 0 to 3 in order
	function automatic logic [15:0] crc_update(input logic [15:0] c_in, input logic [31:0] d);
		logic [15:0] c;
		c = c_in;
		for (int k = 0; k < 4; k++) begin
			c = c ^ {8'h00, d[8*k +: 8]};
			repeat (8) begin
				c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
			end
		end
		return c;
	endfunction

	function automatic int burst_words(input burst_t b);
		return (b.dt == `CSI_DT_RAW8) ? int'(b.wc / 4) + 2 : 1;
	endfunction

	task automatic model_word(input logic [31:0] w, input logic bad_crc);
		if (m_armed && m_left != '0) begin
			pix_exp.push_back('{data: w, addr: m_addr, column: m_col, line: m_line});
			m_left = m_left - 1;
			m_addr = m_addr + 1;
			m_col = m_col + 1;
			m_crc = crc_update(m_crc, w);
		end else if (m_armed) begin
			crc_exp.push_back('{calc: m_crc, recv: w[15:0], match: !bad_crc});
			m_armed = 1'b0;
			m_line = m_line + 1;
		end
	endtask

	// the first valid non-zero word is the header and the rest is payload
	task automatic model_burst(input logic bad_crc);
		logic in_pkt;
		in_pkt = 1'b0;
		foreach (words_q[i]) begin
			if (in_pkt) begin
				model_word(words_q[i], bad_crc);
			end else if (words_q[i] != '0 &&
				words_q[i][31:24] == {2'b00, header_ecc(words_q[i][23:0])}) begin
				in_pkt = 1'b1;
				if (words_q[i][5:0] == `CSI_DT_FRAME_START) begin
					m_armed = 1'b0;
					m_addr = '0;
					m_col = '0;
					m_line = '0;
				end
				if (words_q[i][5:0] == `CSI_DT_RAW8) begin
					m_armed = 1'b1;
					m_left = words_q[i][23:8] >> 2;
					m_col = '0;
					m_crc = `CSI_CRC_INIT;
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic add_burst(input string name, input logic uneven, input logic [5:0] dt,
		input logic [15:0] wc, input logic bad_ecc, input logic bad_crc);
		names.push_back(name);
		tests.push_back('{uneven: uneven, dt: dt, wc: wc, bad_ecc: bad_ecc, bad_crc: bad_crc});
	endtask

	// serial lsb-first bit stream of a lane delayed by shift bits
	function automatic logic [3:0] lane_nibble(input logic lane1, input int n, input int shift);
		logic [3:0] r;
		logic [7:0] byte_v;
		int         b;
		for (int j = 0; j < 4; j++) begin
			b = 4 * n + j - shift;
			if (b < 0 || b >= 8 * lane0_q.size()) begin
				r[j] = 1'b0;
			end else begin
				byte_v = lane1 ? lane1_q[b / 8] : lane0_q[b / 8];
				r[j] = byte_v[b % 8];
			end
		end
		return r;
	endfunction

	task automatic run_burst(input int t);
		burst_t      b;
		logic [31:0] hdr;
		logic [31:0] d;
		logic [15:0] crc;
		int          ncyc;
		b = tests[t];
		cur_name = names[t];
		// each frame replays the same payload sequence
		if (b.dt == `CSI_DT_FRAME_START) begin
			seed = SEED;
		end
		words_q.delete();
		hdr[23:0] = {b.wc, 2'b00, b.dt};
		hdr[31:24] = {2'b00, header_ecc(hdr[23:0])} ^ {7'd0, b.bad_ecc};
		words_q.push_back(hdr);
		if (b.dt == `CSI_DT_RAW8) begin
			crc = `CSI_CRC_INIT;
			for (int i = 0; i < b.wc / 4; i++) begin
				d = $random(seed);
				crc = crc_update(crc, d);
				words_q.push_back(d);
			end
			words_q.push_back({16'h0000, crc ^ {15'd0, b.bad_crc}});
		end
		model_burst(b.bad_crc);
		lane0_q.delete();
		lane1_q.delete();
		for (int i = 0; i < 3; i++) begin
			lane0_q.push_back(i == 2 ? `CSI_SYNC_BYTE : 8'h00);
			lane1_q.push_back(i == 2 ? `CSI_SYNC_BYTE : 8'h00);
		end
		// lane 0 takes bytes 0 and 2 and lane 1 takes bytes 1 and 3
		foreach (words_q[i]) begin
			lane0_q.push_back(words_q[i][7:0]);
			lane0_q.push_back(words_q[i][23:16]);
			lane1_q.push_back(words_q[i][15:8]);
			lane1_q.push_back(words_q[i][31:24]);
		end
		ncyc = 2 * lane0_q.size() + 3;
		for (int n = 0; n < ncyc; n++) begin
			@(posedge mipi_clk_2);
			#1;
			hs_active_i = 1'b1;
			lane0_nibble_i = lane_nibble(1'b0, n, b.uneven ? 2 : 0);
			lane1_nibble_i = lane_nibble(1'b1, n, b.uneven ? 2 : 0);
		end
		@(posedge mipi_clk_2);
		#1;
		hs_active_i = 1'b0;
		lane0_nibble_i = '0;
		lane1_nibble_i = '0;
		repeat (9) @(posedge mipi_clk_2);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_pixel(input pixel_word_t act);
		pixel_word_t exp;
		if (pix_exp.size() == 0) begin
			report_failure($sformatf("%s: pixel strobe while no pixel word was expected",
				cur_name));
		end else begin
			exp = pix_exp.pop_front();
			if (act !== exp) begin
				report_failure($sformatf(
					"FAILED %s pixel expected %h/%0d/%0d/%0d actual %h/%0d/%0d/%0d",
					cur_name, exp.data, exp.addr, exp.column, exp.line,
					act.data, act.addr, act.column, act.line));
			end
		end
	endtask

	task automatic check_crc(input crc_result_t act);
		crc_result_t exp;
		if (crc_exp.size() == 0) begin
			report_failure($sformatf("%s: CRC strobe while no footer was expected", cur_name));
		end else begin
			exp = crc_exp.pop_front();
			if (act !== exp) begin
				report_failure($sformatf("FAILED %s crc expected %h/%h/%b actual %h/%h/%b",
					cur_name, exp.calc, exp.recv, exp.match, act.calc, act.recv, act.match));
			end
		end
	endtask

	always @(negedge mipi_clk_2) begin
		if (!reset && pix_valid_o) begin
			check_pixel(pixel_o);
		end
	end

	always @(negedge mipi_clk_2) begin
		if (!reset && crc_valid_o) begin
			check_crc(crc_o);
		end
	end

	always @(posedge mipi_clk_2) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= limit) begin
			report_failure($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
		end
	end

	initial begin
		reset = 1'b1;
		hs_active_i = 1'b0;
		lane0_nibble_i = '0;
		lane1_nibble_i = '0;
		//        name              uneven dt                  wc      ecc   crc
		add_burst("fs_even",        1'b0, `CSI_DT_FRAME_START, 16'd1,  1'b0, 1'b0);
		add_burst("raw8_even",      1'b0, `CSI_DT_RAW8,        16'd16, 1'b0, 1'b0);
		add_burst("fs_uneven",      1'b1, `CSI_DT_FRAME_START, 16'd1,  1'b0, 1'b0);
		add_burst("raw8_uneven",    1'b1, `CSI_DT_RAW8,        16'd16, 1'b0, 1'b0);
		add_burst("raw8_second",    1'b0, `CSI_DT_RAW8,        16'd16, 1'b0, 1'b0);
		add_burst("raw8_bad_crc",   1'b1, `CSI_DT_RAW8,        16'd8,  1'b0, 1'b1);
		add_burst("raw8_bad_ecc",   1'b0, `CSI_DT_RAW8,        16'd16, 1'b1, 1'b0);
		add_burst("raw8_after_ecc", 1'b1, `CSI_DT_RAW8,        16'd12, 1'b0, 1'b0);
		add_burst("fs_restart",     1'b0, `CSI_DT_FRAME_START, 16'd2,  1'b0, 1'b0);
		add_burst("raw8_restart",   1'b0, `CSI_DT_RAW8,        16'd8,  1'b0, 1'b0);
		limit = 203;
		foreach (tests[i]) begin
			limit += 4 * burst_words(tests[i]) + 19;
		end
		repeat (3) @(posedge mipi_clk_2);
		#1;
		reset = 1'b0;
		for (int t = 0; t < tests.size(); t++) begin
			run_burst(t);
		end
		if (pix_exp.size() != 0 || crc_exp.size() != 0) begin
			report_failure($sformatf("%0d pixel words and %0d CRC results never arrived",
				pix_exp.size(), crc_exp.size()));
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src/csi_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_defines.svh"

module csi_rx_top (
	input  logic                     mipi_clk_2,
	input  logic                     reset,
	input  logic                     hs_active_i,
	input  logic [`CSI_NIBBLE_W-1:0] lane0_nibble_i,
	input  logic [`CSI_NIBBLE_W-1:0] lane1_nibble_i,
	output csi_rx_pkg::pixel_word_t  pixel_o,
	output logic                     pix_valid_o,
	output csi_rx_pkg::crc_result_t  crc_o,
	output logic                     crc_valid_o
);

	import csi_rx_pkg::*;

	logic                   sync;
	logic                   even;
	logic [`CSI_BYTE_W-1:0] lane0_byte;
	logic [`CSI_BYTE_W-1:0] lane1_byte;
	logic                   lane0_valid;
	logic                   lane1_valid;
	lane_bytes_t            lane_bytes;
	pkt_header_t            header;
	logic [`CSI_WORD_W-1:0] payload_word;
	logic                   payload_valid;

	// lane 0 carries the sync byte and sets alignment for both lanes
	csi_sync_detector u_sync (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.hs_active_i   (hs_active_i),
		.lane_nibble_i (lane0_nibble_i),
		.sync_o        (sync),
		.even_o        (even)
	);

	csi_lane_aligner u_align0 (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.hs_active_i   (hs_active_i),
		.sync_i        (sync),
		.even_i        (even),
		.lane_nibble_i (lane0_nibble_i),
		.byte_o        (lane0_byte),
		.byte_valid_o  (lane0_valid)
	);

	csi_lane_aligner u_align1 (
		.mipi_clk_2    (mipi_clk_2),
		.reset         (reset),
		.hs_active_i   (hs_active_i),
		.sync_i        (sync),
		.even_i        (even),
		.lane_nibble_i (lane1_nibble_i),
		.byte_o        (lane1_byte),
		.byte_valid_o  (lane1_valid)
	);

	assign lane_bytes = '{
		lane1_byte: lane1_byte,
		lane0_byte: lane0_byte,
		valid:      lane0_valid & lane1_valid
	};

	csi_header_decoder u_header (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.hs_active_i  (hs_active_i),
		.lane_bytes_i (lane_bytes),
		.header_o     (header),
		.word_o       (payload_word),
		.word_valid_o (payload_valid)
	);

	csi_line_writer u_writer (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.header_i     (header),
		.word_i       (payload_word),
		.word_valid_i (payload_valid),
		.pixel_o      (pixel_o),
		.pix_valid_o  (pix_valid_o),
		.crc_o        (crc_o),
		.crc_valid_o  (crc_valid_o)
	);

endmodule

`default_nettype wire

/* src/csi_line_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_defines.svh"

module csi_line_writer (
	input  logic                    mipi_clk_2,
	input  logic                    reset,
	input  csi_rx_pkg::pkt_header_t header_i,
	input  logic [`CSI_WORD_W-1:0]  word_i,
	input  logic                    word_valid_i,
	output csi_rx_pkg::pixel_word_t pixel_o,
	output logic                    pix_valid_o,
	output csi_rx_pkg::crc_result_t crc_o,
	output logic                    crc_valid_o
);

	import csi_rx_pkg::*;

	logic                   armed;
	logic [`CSI_WC_W-1:0]   words_left;
	logic [`CSI_ADDR_W-1:0] addr_q;
	logic [`CSI_ADDR_W-1:0] col_q;
	logic [`CSI_ADDR_W-1:0] line_q;
	logic [`CSI_CRC_W-1:0]  crc_q;
	logic [`CSI_CRC_W-1:0]  crc_next;
	logic                   payload_hit;
	logic                   footer_hit;

	//////////////////////////////////////////////////////////////////////
	// payload CRC
	//////////////////////////////////////////////////////////////////////

	// byte 0 first, each byte lsb first
	function automatic logic [`CSI_CRC_W-1:0] crc16_word(
		input logic [`CSI_CRC_W-1:0]  crc_in,
		input logic [`CSI_WORD_W-1:0] d
	);
		logic [`CSI_CRC_W-1:0] c;
		logic                  fb;
		c = crc_in;
		for (int i = 0; i < `CSI_WORD_W; i++) begin
			fb = c[0] ^ d[i];
			c = c >> 1;
			if (fb) begin
				c = c ^ `CSI_CRC_POLY;
			end
		end
		return c;
	endfunction

	assign crc_next = crc16_word(crc_q, word_i);

	assign payload_hit = word_valid_i && armed && (words_left != '0);
	// first word past the payload holds the CRC in its low half
	assign footer_hit = word_valid_i && armed && (words_left == '0);

	//////////////////////////////////////////////////////////////////////
	// frame position and packet state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			armed <= 1'b0;
			words_left <= '0;
			addr_q <= '0;
			col_q <= '0;
			line_q <= '0;
			crc_q <= `CSI_CRC_INIT;
			pix_valid_o <= 1'b0;
			crc_valid_o <= 1'b0;
		end else begin
			pix_valid_o <= payload_hit;
			crc_valid_o <= footer_hit;
			if (header_i.valid) begin
				if (header_i.data_type == `CSI_DT_FRAME_START) begin
					armed <= 1'b0;
					addr_q <= '0;
					col_q <= '0;
					line_q <= '0;
				end
				if (header_i.data_type == `CSI_DT_RAW8) begin
					// RAW8 packs four pixels per word
					armed <= 1'b1;
					words_left <= header_i.word_count >> 2;
					col_q <= '0;
					crc_q <= `CSI_CRC_INIT;
				end
			end else if (payload_hit) begin
				words_left <= words_left - 1'b1;
				addr_q <= addr_q + 1'b1;
				col_q <= col_q + 1'b1;
				crc_q <= crc_next;
			end else if (footer_hit) begin
				armed <= 1'b0;
				line_q <= line_q + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output words
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (payload_hit) begin
			pixel_o <= '{data: word_i, addr: addr_q, column: col_q, line: line_q};
		end
		if (footer_hit) begin
			crc_o.calc <= crc_q;
			crc_o.recv <= word_i[15:0];
			crc_o.match <= (crc_q == word_i[15:0]);
		end
	end

endmodule

`default_nettype wire

/* src/csi_header_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_defines.svh"

module csi_header_decoder (
	input  logic                    mipi_clk_2,
	input  logic                    reset,
	input  logic                    hs_active_i,
	input  csi_rx_pkg::lane_bytes_t lane_bytes_i,
	output csi_rx_pkg::pkt_header_t header_o,
	output logic [`CSI_WORD_W-1:0]  word_o,
	output logic                    word_valid_o
);

	import csi_rx_pkg::*;

	logic                          pair_seen;
	logic [2*`CSI_BYTE_W-1:0]      low_half;
	logic [`CSI_WORD_W-1:0]        word_q;
	logic                          word_done;
	logic                          in_packet;
	logic [5:0]                    ecc_calc;
	logic                          header_hit;
	logic                          hdr_valid;
	logic [`CSI_DT_W-1:0]          hdr_type;
	logic [`CSI_WC_W-1:0]          hdr_count;

	//////////////////////////////////////////////////////////////////////
	// header ECC
	//////////////////////////////////////////////////////////////////////

	// six parity bits over data id and word count
	function automatic logic [5:0] calc_ecc(input logic [23:0] d);
		logic [5:0] p;
		p[0] = ^(d & 24'hF12CB7);
		p[1] = ^(d & 24'hF2555B);
		p[2] = ^(d & 24'h749A6D);
		p[3] = ^(d & 24'hB8E38E);
		p[4] = ^(d & 24'hDF03F0);
		p[5] = ^(d & 24'hEFFC00);
		return p;
	endfunction

	assign ecc_calc = calc_ecc(word_q[23:0]);

	// ECC byte has its top two bits zero, all-zero filler is ignored
	assign header_hit = word_done && !in_packet &&
		(word_q[31:24] == {2'b00, ecc_calc}) && (word_q != '0);

	//////////////////////////////////////////////////////////////////////
	// word assembly
	//////////////////////////////////////////////////////////////////////

	// first byte pair fills the low half, lane 0 is the lower byte
	always_ff @(posedge mipi_clk_2) begin
		if (lane_bytes_i.valid) begin
			if (!pair_seen) begin
				low_half <= {lane_bytes_i.lane1_byte, lane_bytes_i.lane0_byte};
			end else begin
				word_q <= {lane_bytes_i.lane1_byte, lane_bytes_i.lane0_byte, low_half};
			end
		end
		if (header_hit) begin
			hdr_type <= word_q[5:0];
			hdr_count <= word_q[23:8];
		end
		if (word_done) begin
			word_o <= word_q;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			pair_seen <= 1'b0;
			word_done <= 1'b0;
			in_packet <= 1'b0;
			hdr_valid <= 1'b0;
			word_valid_o <= 1'b0;
		end else begin
			word_done <= 1'b0;
			if (lane_bytes_i.valid) begin
				pair_seen <= !pair_seen;
				word_done <= pair_seen;
			end
			hdr_valid <= header_hit;
			if (header_hit) begin
				in_packet <= 1'b1;
			end
			// words after the header go out as payload
			word_valid_o <= word_done && in_packet;
		end
	end

	assign header_o = '{
		data_type:  hdr_type,
		word_count: hdr_count,
		valid:      hdr_valid
	};

endmodule

`default_nettype wire

/* src/csi_lane_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_defines.svh"

module csi_lane_aligner (
	input  logic                     mipi_clk_2,
	input  logic                     reset,
	input  logic                     hs_active_i,
	input  logic                     sync_i,
	input  logic                     even_i,
	input  logic [`CSI_NIBBLE_W-1:0] lane_nibble_i,
	output logic [`CSI_BYTE_W-1:0]   byte_o,
	output logic                     byte_valid_o
);

	logic [`CSI_BYTE_W-1:0] even_byte;
	logic [`CSI_BYTE_W-1:0] uneven_byte;
	logic [`CSI_BYTE_W-1:0] even_next;
	logic [`CSI_BYTE_W-1:0] uneven_next;
	logic [1:0]             prev_hi;
	logic                   toggle;

	//////////////////////////////////////////////////////////////////////
	// byte assembly
	//////////////////////////////////////////////////////////////////////

	// whole nibbles, newest one in the upper half
	assign even_next = {lane_nibble_i, even_byte[7:4]};

	// two-bit offset: low bits of this nibble follow the high bits
	// of the previous one
	assign uneven_next = {lane_nibble_i[1:0], prev_hi, uneven_byte[7:4]};

	always_ff @(posedge mipi_clk_2) begin
		even_byte <= even_next;
		uneven_byte <= uneven_next;
		prev_hi <= lane_nibble_i[3:2];
		if (sync_i && toggle) begin
			byte_o <= even_i ? even_next : uneven_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// byte strobe, every second cycle after sync
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			toggle <= 1'b0;
			byte_valid_o <= 1'b0;
		end else if (sync_i) begin
			toggle <= !toggle;
			byte_valid_o <= toggle;
		end else begin
			toggle <= 1'b0;
			byte_valid_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/csi_sync_detector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_rx_defines.svh"

module csi_sync_detector (
	input  logic                     mipi_clk_2,
	input  logic                     reset,
	input  logic                     hs_active_i,
	input  logic [`CSI_NIBBLE_W-1:0] lane_nibble_i,
	output logic                     sync_o,
	output logic                     even_o
);

	localparam logic [`CSI_BYTE_W-1:0] SYNC_BYTE = `CSI_SYNC_BYTE;

	logic [`CSI_NIBBLE_W-1:0] prev_nibble;
	logic [`CSI_BYTE_W-1:0]   window;
	logic                     match_even;
	logic                     match_uneven;

	//////////////////////////////////////////////////////////////////////
	// sync byte search
	//////////////////////////////////////////////////////////////////////

	// newest nibble on top, serial order is lsb first
	assign window = {lane_nibble_i, prev_nibble};

	// byte starts on a nibble boundary
	assign match_even = (window == SYNC_BYTE);

	// byte starts two bits into a nibble, so its upper six bits
	// land in the low six bits of the window
	assign match_uneven = (window[5:0] == SYNC_BYTE[7:2]);

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !hs_active_i) begin
			prev_nibble <= '0;
			sync_o <= 1'b0;
			even_o <= 1'b0;
		end else begin
			prev_nibble <= lane_nibble_i;
			// first hit wins, held until the burst ends
			if (!sync_o && (match_even || match_uneven)) begin
				sync_o <= 1'b1;
				even_o <= match_even;
			end
		end
	end

endmodule

`default_nettype wire

/* src/csi_rx_pkg.sv */
`default_nettype none

package csi_rx_pkg;

	`include "csi_rx_defines.svh"

	//////////////////////////////////////////////////////////////////////
	// aligned bytes and headers
	//////////////////////////////////////////////////////////////////////

	// one byte from each lane, same strobe for both
	typedef struct packed {
		logic [`CSI_BYTE_W-1:0] lane1_byte;
		logic [`CSI_BYTE_W-1:0] lane0_byte;
		logic                   valid;
	} lane_bytes_t;

	// decoded packet header, valid is a one cycle strobe
	typedef struct packed {
		logic [`CSI_DT_W-1:0] data_type;
		logic [`CSI_WC_W-1:0] word_count;
		logic                 valid;
	} pkt_header_t;

	//////////////////////////////////////////////////////////////////////
	// line writer results
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`CSI_WORD_W-1:0] data;
		logic [`CSI_ADDR_W-1:0] addr;
		logic [`CSI_ADDR_W-1:0] column;
		logic [`CSI_ADDR_W-1:0] line;
	} pixel_word_t;

	// calc is the running CRC, recv is taken from the footer
	typedef struct packed {
		logic [`CSI_CRC_W-1:0] calc;
		logic [`CSI_CRC_W-1:0] recv;
		logic                  match;
	} crc_result_t;

endpackage

`default_nettype wire

/* src/csi_rx_defines.svh */
`ifndef CSI_RX_DEFINES_SVH
`define CSI_RX_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// lane and word widths
//////////////////////////////////////////////////////////////////////

// one nibble per lane per mipi_clk_2 cycle, first bit in bit 0
`define CSI_NIBBLE_W 4
`define CSI_BYTE_W 8
`define CSI_WORD_W 32

// packet header fields
`define CSI_DT_W 6
`define CSI_WC_W 16

// address, column and line counters
`define CSI_ADDR_W 16

//////////////////////////////////////////////////////////////////////
// protocol constants
//////////////////////////////////////////////////////////////////////

// leader byte of every high-speed burst
`define CSI_SYNC_BYTE 8'hB8

// data types handled by the line writer
`define CSI_DT_FRAME_START 6'h00
`define CSI_DT_RAW8 6'h2A

// payload checksum, x^16 + x^12 + x^5 + 1 in reflected form
`define CSI_CRC_W 16
`define CSI_CRC_INIT 16'hFFFF
`define CSI_CRC_POLY 16'h8408

`endif
